// File: all.f
logic/fis_rx_pkg.sv
logic/fis_rx_decode.sv
logic/fis_rx_store.sv
logic/taskfile_regs.sv
logic/fis_rx_top.sv
test/fis_rx_tb.sv

// File: Makefile
# Verilator build, run and lint for the FIS receive path
VERILATOR ?= verilator
TOP       ?= fis_rx_tb
LOG       ?= sim.log
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/fis_rx_tb.sv
/*
 * Directed testbench for fis_rx_top with a 100 ns mclk.
 * Inputs change 10 ns after the rising edge, outputs are sampled on the falling edge.
 * Every reg_we is logged in order and written into a register memory model.
 * The head dword counts as word 0, so a D2H frame is head plus 4 data dwords.
 */
`timescale 1ns/100ps
`default_nettype none

module fis_rx_tb;

    typedef logic [fis_rx_pkg::reg_addr_bits-1:0] addr_t;

    localparam addr_t fb_base = 10'h300;
    localparam int test_len [7] = '{20, 120, 120, 160, 100, 100, 200}; // cycles per test
    localparam int margin = 200;
    // command bits in the order update_err_sts, update_sig, set_bsy, clear, 7f, 80
    localparam logic [5:0] do_tfd = 6'b10_0000;
    localparam logic [5:0] do_sig = 6'b01_0000;
    localparam logic [5:0] do_bsy = 6'b00_1000;
    localparam logic [5:0] do_clr = 6'b00_0100;
    localparam logic [5:0] do_7f  = 6'b00_0010;
    localparam logic [5:0] do_80  = 6'b00_0001;

    logic mclk;
    logic hba_rst;
    fis_rx_pkg::rx_word_t hba_data_in;
    logic hba_data_in_valid, hba_data_in_ready;
    logic get_rfis, get_sdbfis, get_ufis, get_ignore;
    logic update_err_sts, update_sig, set_update_sig;
    logic set_bsy, clear_bsy_drq, set_sts_7f, set_sts_80, pcmd_fre;
    logic fis_first_vld, get_fis_busy, get_fis_done, fis_ok, fis_err, fis_ferr;
    logic [7:0] tfd_sts, tfd_err;
    logic fis_i, sdb_n, sig_pending, sig_available, reg_we;
    fis_rx_pkg::reg_wr_t reg_wr;

    fis_rx_pkg::reg_wr_t wr_log [$];            // every register write in order
    logic [31:0] regmem [0:(1 << fis_rx_pkg::reg_addr_bits) - 1];
    logic [31:0] fw [0:31];                     // dwords of the current frame
    logic [31:0] rng = 32'd93;
    fis_rx_pkg::tf_t tf_model = '0;             // expected PxTFD
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    fis_rx_top #(.fb_base(fb_base)) UUT (.*);

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;
    end

    always @(negedge mclk) begin                // register memory model
        if (reg_we === 1'b1) begin
            regmem[reg_wr.addr] = reg_wr.wdata;
            wr_log.push_back(reg_wr);
        end
    end

    initial begin : watchdog
        int budget;
        budget = 16 + margin;
        foreach (test_len[i]) budget += test_len[i];
        #(budget * 100);
        $display("watchdog: run did not finish within %0d cycles", budget);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic fis_rx_pkg::reg_wr_t wr_of(input addr_t a, input logic [31:0] d);
        fis_rx_pkg::reg_wr_t w;
        w.addr  = a;
        w.wdata = d;
        return w;
    endfunction

    task automatic check_tf(input string name, input fis_rx_pkg::tf_t got,
                            input fis_rx_pkg::tf_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_wr(input string name, input fis_rx_pkg::reg_wr_t got,
                            input fis_rx_pkg::reg_wr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got addr %h data %h expected addr %h data %h",
                     name, got.addr, got.wdata, exp.addr, exp.wdata);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge mclk);
            #10;
        end
    endtask

    task automatic pulse_cmds(input logic [5:0] cmd);
        {update_err_sts, update_sig, set_bsy, clear_bsy_drq, set_sts_7f, set_sts_80} = cmd;
        tick(1);
        {update_err_sts, update_sig, set_bsy, clear_bsy_drq, set_sts_7f, set_sts_80} = '0;
    endtask

    task automatic wait_writes(input int target, input int budget);
        int waited;
        waited = 0;
        while (wr_log.size() < target && waited < budget) begin
            tick(1);
            waited++;
        end
        if (wr_log.size() < target) begin
            $display("expected register write did not appear within %0d cycles", budget);
            errors++;
        end
    endtask

    task automatic push_word(input logic [31:0] w, input fis_rx_pkg::rx_type_e t,
                             output bit ok);
        int waited;
        waited = 0;
        hba_data_in       = '{dword: w, tag: t};
        hba_data_in_valid = 1'b1;
        @(negedge mclk);
        while (!hba_data_in_ready && waited < 20) begin
            @(negedge mclk);
            waited++;
        end
        ok = hba_data_in_ready;
        tick(1);                                // consumed at this edge when ready
        hba_data_in_valid = 1'b0;
    endtask

    // head and n-1 data dwords, then one end dword
    task automatic run_frame(input fis_rx_pkg::fis_kind_e kind, input int n, input logic bad);
        bit ok;
        for (int i = 0; i < n; i++) begin
            rng   = xorshift(rng);
            fw[i] = rng;
        end
        hba_data_in       = '{dword: fw[0], tag: fis_rx_pkg::fis_head};
        hba_data_in_valid = 1'b1;               // head waits for the caller's decision
        tick(2);
        check_bit("fis_first_vld", fis_first_vld, 1'b1);
        get_rfis   = kind == fis_rx_pkg::rfis;
        get_sdbfis = kind == fis_rx_pkg::sdb;
        get_ufis   = kind == fis_rx_pkg::ufis;
        get_ignore = kind == fis_rx_pkg::ignore;
        tick(1);
        {get_rfis, get_sdbfis, get_ufis, get_ignore} = '0;
        for (int i = 0; i <= n; i++) begin
            if (i == n)
                push_word(32'h0, bad ? fis_rx_pkg::end_err : fis_rx_pkg::end_ok, ok);
            else
                push_word(fw[i], (i == 0) ? fis_rx_pkg::fis_head : fis_rx_pkg::data, ok);
            if (!ok) begin
                $display("stream stalled, dword %0d of the frame was never accepted", i);
                errors++;
                return;
            end
        end
        if (get_fis_done !== 1'b1) begin
            $display("get_fis_done did not follow the end dword");
            errors++;
        end
        tick(3);                                // storage writes drain
    endtask

    task automatic check_frame(input addr_t base, input int n, input int first);
        check_count("reg_we count", wr_log.size() - first, n);
        for (int i = 0; i < n && first + i < wr_log.size(); i++)
            check_wr("reg_wr", wr_log[first + i], wr_of(addr_t'(base + i), fw[i]));
    endtask

    task automatic end_test(input string name, input int e0);
        tests_run++;
        if (errors == e0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - e0);
            tests_failed++;
        end
    endtask

    task automatic test_d2h();
        int e0 = errors;
        int n0 = wr_log.size();
        logic [31:0] sig;
        pcmd_fre = 1'b1;
        run_frame(fis_rx_pkg::rfis, 5, 1'b0);
        check_bit("fis_ok", fis_ok, 1'b1);
        check_frame(fb_base + fis_rx_pkg::rfis_offs, 5, n0);
        tf_model.err = fw[0][31:24];            // D2H error byte
        tf_model.sts = fw[0][23:16];
        check_tf("tfd", {tfd_err, tfd_sts}, tf_model);
        check_bit("sig_available", sig_available, 1'b1);
        sig = {fw[1][23:0], fw[3][7:0]};
        n0  = wr_log.size();
        pulse_cmds(do_sig);
        wait_writes(n0 + 1, 8);
        check_wr("PxSIG", wr_of(fis_rx_pkg::pxsig_offs, regmem[fis_rx_pkg::pxsig_offs]),
                 wr_of(fis_rx_pkg::pxsig_offs, sig));
        check_bit("sig_pending", sig_pending, 1'b0);
        check_bit("sig_available", sig_available, 1'b0);
        end_test("d2h", e0);
    endtask

    task automatic test_sdb();
        int e0 = errors;
        int n0;
        pulse_cmds(do_7f | do_80);              // BSY and DRQ set beforehand
        tf_model.sts = 8'hff;
        tick(4);
        n0 = wr_log.size();
        run_frame(fis_rx_pkg::sdb, 2, 1'b0);
        check_frame(fb_base + fis_rx_pkg::sdbfis_offs, 2, n0);
        tf_model.err = fw[0][15:8];
        tf_model.sts = {1'b1, fw[0][6:4], 1'b1, fw[0][2:0]}; // BSY, DRQ kept
        check_tf("tfd", {tfd_err, tfd_sts}, tf_model);
        check_bit("fis_i", fis_i, fw[0][14]);
        check_bit("sdb_n", sdb_n, fw[0][15]);
        n0 = wr_log.size();
        pulse_cmds(do_tfd);
        wait_writes(n0 + 1, 8);
        check_wr("PxTFD", wr_log[$], wr_of(fis_rx_pkg::pxtfd_offs, {16'h0, tf_model}));
        end_test("sdb", e0);
    endtask

    task automatic test_ufis();
        int e0 = errors;
        int n0 = wr_log.size();
        run_frame(fis_rx_pkg::ufis, 6, 1'b1);
        check_bit("fis_err", fis_err, 1'b1);
        check_bit("fis_ok", fis_ok, 1'b0);
        check_frame(fb_base + fis_rx_pkg::ufis_offs, 6, n0);
        pcmd_fre = 1'b0;                        // receive disabled, nothing stored
        n0 = wr_log.size();
        run_frame(fis_rx_pkg::ufis, 4, 1'b1);
        check_count("reg_we count", wr_log.size() - n0, 0);
        pcmd_fre = 1'b1;
        end_test("ufis", e0);
    endtask

    task automatic test_too_long();
        int e0 = errors;
        int n0 = wr_log.size();
        run_frame(fis_rx_pkg::rfis, 7, 1'b0);
        check_bit("fis_ferr", fis_ferr, 1'b1);
        check_frame(fb_base + fis_rx_pkg::rfis_offs, 5, n0);
        tf_model.err = fw[0][31:24];
        tf_model.sts = fw[0][23:16];
        check_tf("tfd", {tfd_err, tfd_sts}, tf_model);
        end_test("too_long", e0);
    endtask

    task automatic test_ignore();
        int e0 = errors;
        int n0 = wr_log.size();
        int n;
        rng = xorshift(rng);
        n   = 1 + int'(rng % 20);               // may run past 16 dwords
        run_frame(fis_rx_pkg::ignore, n, 1'b0);
        check_count("reg_we count", wr_log.size() - n0, 0);
        check_bit("fis_ok", fis_ok, 1'b1);
        check_bit("fis_ferr", fis_ferr, 1'b0);
        check_bit("get_fis_busy", get_fis_busy, 1'b0);
        end_test("ignore", e0);
    endtask

    task automatic apply_status(input logic [5:0] cmd, input logic [7:0] exp_sts);
        int n0 = wr_log.size();
        pulse_cmds(cmd);
        wait_writes(n0 + 1, 8);
        tf_model.sts = exp_sts;
        check_tf("tfd", {tfd_err, tfd_sts}, tf_model);
        check_wr("PxTFD", wr_log[$], wr_of(fis_rx_pkg::pxtfd_offs, {16'h0, tf_model}));
    endtask

    task automatic test_status();
        int e0 = errors;
        apply_status(do_7f, 8'h7f);
        apply_status(do_bsy, 8'hff);
        apply_status(do_clr, 8'h77);            // bits 7 and 3 cleared
        apply_status(do_80, 8'h80);
        apply_status(do_clr, 8'h00);
        apply_status(do_7f | do_80, 8'hff);
        apply_status(do_bsy | do_clr, 8'hf7);   // BSY wins, DRQ cleared
        end_test("status", e0);
    endtask

    initial begin
        hba_rst           = 1'b1;
        hba_data_in       = '0;
        hba_data_in_valid = 1'b0;
        {get_rfis, get_sdbfis, get_ufis, get_ignore} = '0;
        {update_err_sts, update_sig, set_bsy, clear_bsy_drq, set_sts_7f, set_sts_80} = '0;
        set_update_sig    = 1'b0;
        pcmd_fre          = 1'b0;
        repeat (16) @(posedge mclk);
        #10 hba_rst = 1'b0;
        tick(2);
        check_bit("reg_we", reg_we, 1'b0);      // reset state
        check_bit("fis_first_vld", fis_first_vld, 1'b0);
        check_bit("sig_pending", sig_pending, 1'b1);
        check_tf("tfd", {tfd_err, tfd_sts}, tf_model);
        end_test("reset", 0);
        test_d2h();
        test_sdb();
        test_ufis();
        test_too_long();
        test_ignore();
        test_status();
        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/fis_rx_top.sv
/*
 * AHCI port receive side for FIS from the SATA transport layer.
 * The caller decodes the FIS type after fis_first_vld and pulses one get_*.
 * The register port has no back-pressure, a write is valid while reg_we is high.
 */
`timescale 1ns/100ps
`default_nettype none

module fis_rx_top #(
    parameter logic [fis_rx_pkg::reg_addr_bits-1:0] fb_base = 10'h300 // receive FIS area
) (
    input  wire                       mclk,
    input  wire                       hba_rst,
    input  wire fis_rx_pkg::rx_word_t  hba_data_in,
    input  wire                       hba_data_in_valid,
    output logic                      hba_data_in_ready,
    input  wire                       get_rfis,
    input  wire                       get_sdbfis,
    input  wire                       get_ufis,
    input  wire                       get_ignore,
    input  wire                       update_err_sts,
    input  wire                       update_sig,
    input  wire                       set_update_sig,
    input  wire                       set_bsy,
    input  wire                       clear_bsy_drq,
    input  wire                       set_sts_7f,
    input  wire                       set_sts_80,
    input  wire                       pcmd_fre,
    output logic                      fis_first_vld,
    output logic                      get_fis_busy,
    output logic                      get_fis_done,
    output logic                      fis_ok,
    output logic                      fis_err,
    output logic                      fis_ferr,
    output logic [7:0]                tfd_sts,
    output logic [7:0]                tfd_err,
    output logic                      fis_i,
    output logic                      sdb_n,
    output logic                      sig_pending,
    output logic                      sig_available,
    output fis_rx_pkg::reg_wr_t       reg_wr,
    output logic                      reg_we
);

    fis_rx_pkg::fis_desc_t fis_desc;
    fis_rx_pkg::reg_wr_t   fis_wr;
    fis_rx_pkg::rx_word_t  rx_word;
    fis_rx_pkg::fis_kind_e cur_kind;
    fis_rx_pkg::tf_t       tfd;
    logic                  desc_load;
    logic                  fis_wr_en;
    logic [3:0]            word_idx;
    logic                  word_take;

    assign tfd_sts = tfd.sts;
    assign tfd_err = tfd.err;

    fis_rx_decode #(.fb_base(fb_base)) u_decode (
        .mclk, .hba_rst, .get_rfis, .get_sdbfis, .get_ufis, .get_ignore, .pcmd_fre,
        .sig_pending, .hba_data_in, .hba_data_in_valid, .fis_busy(get_fis_busy),
        .fis_desc, .desc_load, .fis_first_vld
    );

    fis_rx_store u_store (
        .mclk, .hba_rst, .fis_desc, .desc_load, .hba_data_in, .hba_data_in_valid,
        .hba_data_in_ready, .fis_wr, .fis_wr_en, .rx_word, .word_idx, .word_take, .cur_kind,
        .fis_busy(get_fis_busy), .get_fis_done, .fis_ok, .fis_err, .fis_ferr
    );

    taskfile_regs u_taskfile (
        .mclk, .hba_rst, .rx_word, .word_idx, .word_take, .cur_kind, .fis_wr, .fis_wr_en,
        .update_err_sts, .update_sig, .set_update_sig, .set_bsy, .clear_bsy_drq,
        .set_sts_7f, .set_sts_80, .tfd, .fis_i, .sdb_n, .sig_pending, .sig_available,
        .reg_wr, .reg_we
    );

endmodule

`default_nettype wire

// File: logic/taskfile_regs.sv
/*
 * PxTFD status/error and device signature, plus the register write port.
 * Storage writes leave one cycle after fis_wr_en and always win the port.
 * PxTFD and PxSIG updates leave two cycles after their pulse unless
 * storage writes are in flight, then they wait.
 * Status commands arriving with a D2H or SDB word 0 are lost.
 */
`timescale 1ns/100ps
`default_nettype none

module taskfile_regs (
    input  wire                        mclk,
    input  wire                        hba_rst,
    input  wire fis_rx_pkg::rx_word_t   rx_word,
    input  wire [3:0]                  word_idx,
    input  wire                        word_take,
    input  wire fis_rx_pkg::fis_kind_e  cur_kind,
    input  wire fis_rx_pkg::reg_wr_t    fis_wr,
    input  wire                        fis_wr_en,
    input  wire                        update_err_sts,
    input  wire                        update_sig,
    input  wire                        set_update_sig,
    input  wire                        set_bsy,
    input  wire                        clear_bsy_drq,
    input  wire                        set_sts_7f,
    input  wire                        set_sts_80,
    output fis_rx_pkg::tf_t            tfd,
    output logic                       fis_i,
    output logic                       sdb_n,
    output logic                       sig_pending,
    output logic                       sig_available,
    output fis_rx_pkg::reg_wr_t        reg_wr,
    output logic                       reg_we
);

    fis_rx_pkg::tf_t tf_n;
    logic [31:0]     sig_r;
    logic            tfd_wq;                   // PxTFD write waiting for the port
    logic            sig_wq;                   // PxSIG write waiting

    wire [31:0] dw      = rx_word.dword;
    wire        d2h     = word_take && cur_kind == fis_rx_pkg::rfis;
    wire        sdb     = word_take && cur_kind == fis_rx_pkg::sdb;
    wire        sts_cmd = set_bsy | clear_bsy_drq | set_sts_7f | set_sts_80;
    wire        sig_w1  = d2h && sig_pending && word_idx == 4'd1;
    wire        sig_w3  = d2h && sig_pending && word_idx == 4'd3;

    always_comb begin
        tf_n = tfd;
        if (d2h && word_idx == 4'd0) begin
            tf_n = fis_rx_pkg::tf_t'(dw[31:16]);       // error and status of D2H
        end else if (sdb && word_idx == 4'd0) begin
            tf_n.err = dw[15:8];
            tf_n.sts = dw[7:0];
            tf_n.sts[fis_rx_pkg::sts_bsy] = tfd.sts[fis_rx_pkg::sts_bsy]; // SDB can't touch BSY
            tf_n.sts[fis_rx_pkg::sts_drq] = tfd.sts[fis_rx_pkg::sts_drq]; // nor DRQ
        end else if (set_sts_7f || set_sts_80) begin
            tf_n.sts = {set_sts_80, {7{set_sts_7f}}}; // both give 0xff
        end else begin
            if (clear_bsy_drq) begin
                tf_n.sts[fis_rx_pkg::sts_bsy] = 1'b0;
                tf_n.sts[fis_rx_pkg::sts_drq] = 1'b0;
            end
            if (set_bsy) tf_n.sts[fis_rx_pkg::sts_bsy] = 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) tfd <= '0;
        else         tfd <= tf_n;

        if (sig_w1) sig_r[31:8] <= dw[23:0];  // lba low, mid, high
        if (sig_w3) sig_r[7:0]  <= dw[7:0];   // sector count

        if ((d2h || sdb) && word_idx == 4'd0) fis_i <= dw[14];
        if (sdb && word_idx == 4'd0)          sdb_n <= dw[15];

        if (hba_rst || set_update_sig) sig_pending <= 1'b1;
        else if (update_sig)           sig_pending <= 1'b0;

        if (hba_rst || update_sig) sig_available <= 1'b0;
        else if (sig_w3)           sig_available <= 1'b1;
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            tfd_wq <= 1'b0;
            sig_wq <= 1'b0;
            reg_we <= 1'b0;
        end else begin
            reg_we <= fis_wr_en | tfd_wq | sig_wq;
            if (update_err_sts || sts_cmd) tfd_wq <= 1'b1;
            else if (!fis_wr_en)           tfd_wq <= 1'b0;
            if (update_sig && sig_pending)   sig_wq <= 1'b1;
            else if (!fis_wr_en && !tfd_wq)  sig_wq <= 1'b0;
        end

        if (fis_wr_en)   reg_wr <= fis_wr;    // storage first
        else if (tfd_wq) reg_wr <= '{addr: fis_rx_pkg::pxtfd_offs, wdata: {16'h0, tfd}};
        else if (sig_wq) reg_wr <= '{addr: fis_rx_pkg::pxsig_offs, wdata: sig_r};
    end

endmodule

`default_nettype wire

// File: logic/fis_rx_store.sv
/*
 * Walks one FIS from the input stream and emits its storage writes.
 * The head dword counts as word 0 of the FIS.
 * Ready is combinational and high from desc_load until the end dword.
 * Dwords beyond the FIS length are dropped and flagged as fis_ferr,
 * except for an ignored FIS.
 */
`timescale 1ns/100ps
`default_nettype none

module fis_rx_store (
    input  wire                       mclk,
    input  wire                       hba_rst,
    input  wire fis_rx_pkg::fis_desc_t fis_desc,
    input  wire                       desc_load,
    input  wire fis_rx_pkg::rx_word_t  hba_data_in,
    input  wire                       hba_data_in_valid,
    output logic                      hba_data_in_ready,
    output fis_rx_pkg::reg_wr_t       fis_wr,
    output logic                      fis_wr_en,
    output fis_rx_pkg::rx_word_t      rx_word,
    output logic [3:0]                word_idx,
    output logic                      word_take,
    output fis_rx_pkg::fis_kind_e     cur_kind,
    output logic                      fis_busy,
    output logic                      get_fis_done,
    output logic                      fis_ok,
    output logic                      fis_err,
    output logic                      fis_ferr
);

    fis_rx_pkg::fis_desc_t desc_r;
    fis_rx_pkg::fis_desc_t cur;                // descriptor in use this cycle
    logic                  busy_r;
    logic                  over_r;             // length reached, later dwords dropped
    logic                  drop_r;             // a dword was dropped
    logic [3:0]            cnt_r;
    logic [fis_rx_pkg::reg_addr_bits-1:0] addr_r;
    logic [fis_rx_pkg::reg_addr_bits-1:0] addr_c;
    logic                  take;
    logic                  is_end;
    logic                  word_acc;

    // descriptor is used straight from decode in its load cycle
    assign cur      = desc_load ? fis_desc : desc_r;
    assign addr_c   = desc_load ? fis_desc.base : addr_r;
    assign fis_busy = desc_load | busy_r;

    assign hba_data_in_ready = fis_busy;
    assign take     = fis_busy & hba_data_in_valid;
    assign is_end   = (hba_data_in.tag == fis_rx_pkg::end_ok) ||
                      (hba_data_in.tag == fis_rx_pkg::end_err);
    assign word_acc = take & ~is_end;          // head or data dword

    assign word_take = word_acc & ~over_r;
    assign rx_word   = hba_data_in;
    assign word_idx  = cnt_r;
    assign cur_kind  = cur.kind;

    always_ff @(posedge mclk) begin
        if (desc_load) desc_r <= fis_desc;
        if (word_take)      addr_r <= addr_c + fis_rx_pkg::reg_addr_bits'(1);
        else if (desc_load) addr_r <= fis_desc.base; // head not valid in the load cycle
        fis_wr.addr  <= addr_c;
        fis_wr.wdata <= hba_data_in.dword;
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            busy_r       <= 1'b0;
            over_r       <= 1'b0;
            drop_r       <= 1'b0;
            cnt_r        <= 4'd0;
            fis_wr_en    <= 1'b0;
            get_fis_done <= 1'b0;
            fis_ok       <= 1'b0;
            fis_err      <= 1'b0;
            fis_ferr     <= 1'b0;
        end else begin
            fis_wr_en    <= word_take & cur.save;
            get_fis_done <= take & is_end;

            if (take && is_end) begin          // counters left clear for the next FIS
                busy_r <= 1'b0;
                over_r <= 1'b0;
                drop_r <= 1'b0;
                cnt_r  <= 4'd0;
            end else begin
                if (desc_load) busy_r <= 1'b1;
                if (word_take) begin
                    cnt_r <= cnt_r + 4'd1;
                    if (cnt_r == cur.lenm1) over_r <= 1'b1;
                end
                if (word_acc && over_r && cur.kind != fis_rx_pkg::ignore)
                    drop_r <= 1'b1;            // too long
            end

            if (desc_load) begin
                fis_ok   <= 1'b0;
                fis_err  <= 1'b0;
                fis_ferr <= 1'b0;
            end
            if (take && is_end) begin
                fis_ok   <= hba_data_in.tag == fis_rx_pkg::end_ok;
                fis_err  <= hba_data_in.tag == fis_rx_pkg::end_err;
                fis_ferr <= drop_r;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fis_rx_decode.sv
/*
 * Turns a get_* command pulse into a FIS descriptor one cycle later.
 * Only one get_* pulse may be high in a cycle.
 * fis_first_vld flags a head dword at the stream output while idle.
 */
`timescale 1ns/100ps
`default_nettype none

module fis_rx_decode #(
    parameter logic [fis_rx_pkg::reg_addr_bits-1:0] fb_base
) (
    input  wire                      mclk,
    input  wire                      hba_rst,
    input  wire                      get_rfis,
    input  wire                      get_sdbfis,
    input  wire                      get_ufis,
    input  wire                      get_ignore,
    input  wire                      pcmd_fre,          // FIS receive enable
    input  wire                      sig_pending,       // D2H is saved while waiting for signature
    input  wire fis_rx_pkg::rx_word_t hba_data_in,
    input  wire                      hba_data_in_valid,
    input  wire                      fis_busy,
    output fis_rx_pkg::fis_desc_t    fis_desc,
    output logic                     desc_load,
    output logic                     fis_first_vld
);

    wire get_any = get_rfis | get_sdbfis | get_ufis | get_ignore;

    fis_rx_pkg::fis_desc_t desc_n;

    always_comb begin
        desc_n       = '0;                      // ignore has an unknown length and is never saved
        desc_n.kind  = fis_rx_pkg::ignore;
        desc_n.lenm1 = 4'hf;
        if (get_rfis) begin
            desc_n.kind  = fis_rx_pkg::rfis;
            desc_n.base  = fb_base + fis_rx_pkg::rfis_offs;
            desc_n.lenm1 = fis_rx_pkg::rfis_lenm1;
            desc_n.save  = sig_pending | pcmd_fre; // signature FIS kept even with fre off
        end else if (get_sdbfis) begin
            desc_n.kind  = fis_rx_pkg::sdb;
            desc_n.base  = fb_base + fis_rx_pkg::sdbfis_offs;
            desc_n.lenm1 = fis_rx_pkg::sdbfis_lenm1;
            desc_n.save  = pcmd_fre;
        end else if (get_ufis) begin
            desc_n.kind  = fis_rx_pkg::ufis;
            desc_n.base  = fb_base + fis_rx_pkg::ufis_offs;
            desc_n.lenm1 = fis_rx_pkg::ufis_lenm1;
            desc_n.save  = pcmd_fre;
        end
    end

    always_ff @(posedge mclk) begin
        if (get_any) fis_desc <= desc_n;

        if (hba_rst) desc_load <= 1'b0;
        else         desc_load <= get_any;

        if (hba_rst || fis_busy || get_any)
            fis_first_vld <= 1'b0;              // stays low until the FIS is done
        else if (hba_data_in_valid && hba_data_in.tag == fis_rx_pkg::fis_head)
            fis_first_vld <= 1'b1;
    end

endmodule

`default_nettype wire

// File: logic/fis_rx_pkg.sv
/*
 * Shared types and constants of the AHCI FIS receive path.
 * Register addresses are 32-bit word addresses in a 1K-word register map.
 * Receive-area offsets are relative to the fb_base parameter of the top level.
 */
`default_nettype none

package fis_rx_pkg;

    localparam int reg_addr_bits = 10;         // register word address width

    typedef enum logic [1:0] {
        data     = 2'd0,                       // payload dword
        fis_head = 2'd1,                       // first dword of a FIS, type in low byte
        end_ok   = 2'd2,                       // FIS ended, crc good
        end_err  = 2'd3                        // FIS ended with an error
    } rx_type_e;

    typedef struct packed {
        logic [31:0] dword;
        rx_type_e    tag;
    } rx_word_t;

    typedef enum logic [1:0] {
        rfis   = 2'd0,                         // D2H register FIS
        sdb    = 2'd1,                         // set device bits FIS
        ufis   = 2'd2,                         // unknown FIS
        ignore = 2'd3                          // consume and drop
    } fis_kind_e;

    typedef struct packed {
        fis_kind_e                kind;
        logic [reg_addr_bits-1:0] base;        // first storage word
        logic [3:0]               lenm1;       // FIS length in dwords, minus one
        logic                     save;        // store the dwords into the receive area
    } fis_desc_t;

    typedef struct packed {
        logic [reg_addr_bits-1:0] addr;
        logic [31:0]              wdata;
    } reg_wr_t;

    typedef struct packed {
        logic [7:0] err;
        logic [7:0] sts;
    } tf_t;

    localparam logic [reg_addr_bits-1:0] pxtfd_offs  = 10'h048;
    localparam logic [reg_addr_bits-1:0] pxsig_offs  = 10'h049;
    localparam logic [reg_addr_bits-1:0] rfis_offs   = 10'h010; // from fb_base
    localparam logic [reg_addr_bits-1:0] sdbfis_offs = 10'h016;
    localparam logic [reg_addr_bits-1:0] ufis_offs   = 10'h018;

    localparam logic [3:0] rfis_lenm1   = 4'd4;
    localparam logic [3:0] sdbfis_lenm1 = 4'd1;
    localparam logic [3:0] ufis_lenm1   = 4'd15;

    localparam int sts_bsy = 7;
    localparam int sts_drq = 3;
    localparam int sts_err = 0;

endpackage

`default_nettype wire
